//--- source/spu_types_pkg.sv
package spu_types_pkg;

	localparam int QUAD_W     = 128;	// Register and local-store word width
	localparam int WORD_W     = 32;		// Preferred slot word used for addresses
	localparam int REG_ADDR_W = 7;		// 128 architected registers
	localparam int OPCODE_W   = 11;		// Widest opcode field (RR format)
	localparam int FORMAT_W   = 3;
	localparam int IMM_W      = 18;		// Widest immediate field (RI18)
	localparam int LS_ADDR_W  = 11;		// Quadword index bits
	localparam int LS_DEPTH   = 2048;	// 32 KB of quadwords

	// Big-endian numbering, bit 0 is the leftmost bit
	typedef logic [0:QUAD_W-1] quad_t;

	typedef logic [0:REG_ADDR_W-1] reg_addr_t;

	typedef logic [0:OPCODE_W-1] opcode_t;	// Truncated per format by the decoder

	typedef logic [FORMAT_W-1:0] format_t;

	typedef logic [0:IMM_W-1] imm_t;		// Truncated per format by the decoder

	// Plain index into the local store, wraps at LS_DEPTH
	typedef logic [LS_ADDR_W-1:0] ls_addr_t;

endpackage

//--- source/spu_isa_pkg.sv
package spu_isa_pkg;

	// Instruction format codes as delivered by the issue stage
	localparam spu_types_pkg::format_t FMT_RR   = 3'd0;
	localparam spu_types_pkg::format_t FMT_RI10 = 3'd4;
	localparam spu_types_pkg::format_t FMT_RI16 = 3'd5;

	// x-form, full 11-bit opcode
	localparam spu_types_pkg::opcode_t OP_LQX  = 11'b00111000100;	// Load quadword
	localparam spu_types_pkg::opcode_t OP_STQX = 11'b00101000100;	// Store quadword

	// d-form, matched against opcode bits 3 to 10
	localparam logic [7:0] OP_LQD  = 8'b00110100;
	localparam logic [7:0] OP_STQD = 8'b00100100;

	// a-form, matched against opcode bits 2 to 10
	localparam logic [8:0] OP_LQA  = 9'b001100001;
	localparam logic [8:0] OP_STQA = 9'b001000001;

	// Odd pipe latency from issue to writeback
	localparam int WB_STAGES = 6;

endpackage

//--- source/odd_issue_if.sv
`timescale 1ns/1ps

interface odd_issue_if;
	import spu_types_pkg::*;

	opcode_t   op;			// Decoded opcode
	format_t   format;		// Selects which opcode and immediate bits count
	reg_addr_t rt_addr;		// Destination register
	quad_t     ra;
	quad_t     rb;
	quad_t     rt_st;		// Store data
	imm_t      imm;
	logic      reg_write;	// Instruction writes the register file

	modport source (
		output op, format, rt_addr, ra, rb, rt_st, imm, reg_write
	);

	modport sink (
		input op, format, rt_addr, ra, rb, rt_st, imm, reg_write
	);

endinterface

//--- source/ls_req_if.sv
`timescale 1ns/1ps

interface ls_req_if;
	import spu_types_pkg::*;

	logic      load;		// Quadword load this cycle
	logic      store;		// Quadword store this cycle, never with load
	ls_addr_t  addr;		// Wrapped quadword index
	reg_addr_t rt_addr;		// Zero unless a memory instruction
	logic      reg_write;	// Zero unless a memory instruction
	quad_t     rt_st;

	modport issuer (
		output load, store, addr, rt_addr, reg_write, rt_st
	);

	modport memory (
		input load, store, addr, rt_addr, reg_write, rt_st
	);

endinterface

//--- source/ls_addr_decode.sv
`timescale 1ns/1ps

module ls_addr_decode (
	odd_issue_if.sink issue,
	ls_req_if.issuer  req
);
	import spu_types_pkg::*;
	import spu_isa_pkg::*;

	logic is_lqx;
	logic is_stqx;
	logic is_lqd;
	logic is_stqd;
	logic is_lqa;
	logic is_stqa;
	logic x_form;
	logic d_form;
	logic a_form;

	logic [WORD_W-1:0] word_a;		// Preferred slot of ra
	logic [WORD_W-1:0] word_b;		// Preferred slot of rb
	logic [WORD_W-1:0] imm10_ext;
	logic [WORD_W-1:0] sum_x;
	logic [WORD_W-1:0] sum_d;
	logic [15:0]       imm16;

	assign word_a    = issue.ra[0:WORD_W-1];
	assign word_b    = issue.rb[0:WORD_W-1];
	assign imm10_ext = {{(WORD_W-10){issue.imm[8]}}, issue.imm[8:17]};	// Sign extend I10
	assign imm16     = issue.imm[2:17];

	// Only the low index bits survive, so overflow simply wraps
	assign sum_x = word_a + word_b;
	assign sum_d = word_a + imm10_ext;

	always_comb begin
		is_lqx  = (issue.format == FMT_RR) && (issue.op == OP_LQX);
		is_stqx = (issue.format == FMT_RR) && (issue.op == OP_STQX);
		is_lqd  = (issue.format == FMT_RI10) && (issue.op[3:10] == OP_LQD);
		is_stqd = (issue.format == FMT_RI10) && (issue.op[3:10] == OP_STQD);
		is_lqa  = (issue.format == FMT_RI16) && (issue.op[2:10] == OP_LQA);
		is_stqa = (issue.format == FMT_RI16) && (issue.op[2:10] == OP_STQA);

		x_form = is_lqx | is_stqx;
		d_form = is_lqd | is_stqd;
		a_form = is_lqa | is_stqa;
	end

	always_comb begin
		req.load  = is_lqx | is_lqd | is_lqa;
		req.store = is_stqx | is_stqd | is_stqa;

		if (x_form) begin
			req.addr = sum_x[LS_ADDR_W-1:0];
		end else if (d_form) begin
			req.addr = sum_d[LS_ADDR_W-1:0];
		end else if (a_form) begin
			req.addr = imm16[LS_ADDR_W-1:0];	// Absolute quadword index
		end else begin
			req.addr = '0;
		end

		// Nops and other odd-pipe ops leave nothing for writeback
		if (x_form | d_form | a_form) begin
			req.rt_addr   = issue.rt_addr;
			req.reg_write = issue.reg_write;
		end else begin
			req.rt_addr   = '0;
			req.reg_write = 1'b0;
		end

		req.rt_st = issue.rt_st;
	end

endmodule

//--- source/local_store.sv
`timescale 1ns/1ps

module local_store (
	input  logic                      clk,
	input  logic                      reset,
	ls_req_if.memory                  req,
	output spu_types_pkg::quad_t      rt_wb,
	output spu_types_pkg::reg_addr_t  rt_addr_wb,
	output logic                      reg_write_wb
);
	import spu_types_pkg::*;
	import spu_isa_pkg::*;

	quad_t mem [0:LS_DEPTH-1];		// 32 KB local store

	// Writeback delay line, index 0 is the youngest
	quad_t     [WB_STAGES-1:0] rt_delay;
	reg_addr_t [WB_STAGES-1:0] rt_addr_delay;
	logic      [WB_STAGES-1:0] reg_write_delay;

	quad_t     rd_data;
	quad_t     data_in;
	reg_addr_t addr_in;
	logic      write_in;

	// Asynchronous read gives the contents from before this edge's store
	assign rd_data = mem[req.addr];

	always_comb begin
		data_in  = req.load ? rd_data : '0;
		addr_in  = req.rt_addr;				// Already zero for non-memory ops
		write_in = req.load & req.reg_write;	// Stores never write back
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < LS_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (req.store) begin
			mem[req.addr] <= req.rt_st;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rt_delay        <= '0;
			rt_addr_delay   <= '0;
			reg_write_delay <= '0;
		end else begin
			rt_delay        <= {rt_delay[WB_STAGES-2:0], data_in};	// Shift toward stage 5
			rt_addr_delay   <= {rt_addr_delay[WB_STAGES-2:0], addr_in};
			reg_write_delay <= {reg_write_delay[WB_STAGES-2:0], write_in};
		end
	end

	assign rt_wb        = rt_delay[WB_STAGES-1];
	assign rt_addr_wb   = rt_addr_delay[WB_STAGES-1];
	assign reg_write_wb = reg_write_delay[WB_STAGES-1];

endmodule

//--- source/spu_odd_ls.sv
`timescale 1ns/1ps

module spu_odd_ls (
	input  logic                      clk,
	input  logic                      reset,
	input  spu_types_pkg::opcode_t    op,
	input  spu_types_pkg::format_t    format,
	input  spu_types_pkg::reg_addr_t  rt_addr,
	input  spu_types_pkg::quad_t      ra,
	input  spu_types_pkg::quad_t      rb,
	input  spu_types_pkg::quad_t      rt_st,
	input  spu_types_pkg::imm_t       imm,
	input  logic                      reg_write,
	output spu_types_pkg::quad_t      rt_wb,
	output spu_types_pkg::reg_addr_t  rt_addr_wb,
	output logic                      reg_write_wb
);

	odd_issue_if issue_if ();
	ls_req_if    req_if ();

	// Issue stage values, one instruction per cycle
	assign issue_if.op        = op;
	assign issue_if.format    = format;
	assign issue_if.rt_addr   = rt_addr;
	assign issue_if.ra        = ra;
	assign issue_if.rb        = rb;
	assign issue_if.rt_st     = rt_st;
	assign issue_if.imm       = imm;
	assign issue_if.reg_write = reg_write;

	ls_addr_decode decode_i (
		.issue (issue_if.sink),
		.req   (req_if.issuer)
	);

	local_store ls_i (
		.clk          (clk),
		.reset        (reset),
		.req          (req_if.memory),
		.rt_wb        (rt_wb),
		.rt_addr_wb   (rt_addr_wb),
		.reg_write_wb (reg_write_wb)
	);

endmodule

//--- dv/spu_odd_ls_tb.sv
`timescale 1ns/1ps

module spu_odd_ls_tb;
	import spu_types_pkg::*;
	import spu_isa_pkg::*;

	localparam int CLK_HALF   = 2;		// 4 ns clock
	localparam int NUM_RANDOM = 48;

	// Memory opcodes widened to the full field, high bits zero
	localparam opcode_t LQD_OPCODE  = {3'b000, OP_LQD};
	localparam opcode_t STQD_OPCODE = {3'b000, OP_STQD};
	localparam opcode_t LQA_OPCODE  = {2'b00, OP_LQA};
	localparam opcode_t STQA_OPCODE = {2'b00, OP_STQA};

	// Odd-pipe ops that never touch the local store
	localparam opcode_t RR_OTHER   = 11'b00011000000;
	localparam opcode_t RI10_OTHER = 11'b00000011100;
	localparam opcode_t RI16_OTHER = 11'b00000110010;

	typedef struct packed {
		format_t   format;
		opcode_t   op;
		reg_addr_t rt_addr;
		quad_t     ra;
		quad_t     rb;
		quad_t     rt_st;
		imm_t      imm;
		logic      reg_write;
	} row_t;

	typedef struct packed {
		quad_t     data;
		reg_addr_t rt_addr;
		logic      reg_write;
	} wb_t;

	logic      clk;
	logic      reset;
	opcode_t   op;
	format_t   format;
	reg_addr_t rt_addr;
	quad_t     ra;
	quad_t     rb;
	quad_t     rt_st;
	imm_t      imm;
	logic      reg_write;
	quad_t     rt_wb;
	reg_addr_t rt_addr_wb;
	logic      reg_write_wb;

	row_t  rows [$];		// Stimulus table
	wb_t   expected [$];	// Writebacks still in flight
	quad_t shadow [0:LS_DEPTH-1];

	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int timeout_limit = 0;

	spu_odd_ls dut_i (
		.clk          (clk),
		.reset        (reset),
		.op           (op),
		.format       (format),
		.rt_addr      (rt_addr),
		.ra           (ra),
		.rb           (rb),
		.rt_st        (rt_st),
		.imm          (imm),
		.reg_write    (reg_write),
		.rt_wb        (rt_wb),
		.rt_addr_wb   (rt_addr_wb),
		.reg_write_wb (reg_write_wb)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic quad_t random_quad();
		return {$urandom, $urandom, $urandom, $urandom};
	endfunction

	function automatic imm_t random_imm();
		logic [31:0] w;
		w = $urandom;
		return w[17:0];
	endfunction

	// Leftmost word set, the rest is noise the address must ignore
	function automatic quad_t with_word(input logic [31:0] w);
		return {w, $urandom, $urandom, $urandom};
	endfunction

	task automatic add_row(input format_t f, input opcode_t o, input reg_addr_t rt,
			input quad_t a, input quad_t b, input quad_t st, input imm_t im, input logic wr);
		row_t r;
		r = '{f, o, rt, a, b, st, im, wr};
		rows.push_back(r);
	endtask

	task automatic add_x(input logic is_load, input reg_addr_t rt, input logic [31:0] wa,
			input logic [31:0] wb, input logic wr, input quad_t data);
		add_row(FMT_RR, is_load ? OP_LQX : OP_STQX, rt, with_word(wa), with_word(wb), data,
			random_imm(), wr);
	endtask

	task automatic add_d(input logic is_load, input reg_addr_t rt, input logic [31:0] wa,
			input logic [9:0] imm10, input logic wr, input quad_t data);
		logic [31:0] junk;
		junk = $urandom;
		add_row(FMT_RI10, is_load ? LQD_OPCODE : STQD_OPCODE, rt, with_word(wa), random_quad(),
			data, {junk[7:0], imm10}, wr);
	endtask

	task automatic add_a(input logic is_load, input reg_addr_t rt, input logic [15:0] imm16,
			input logic wr, input quad_t data);
		logic [31:0] junk;
		junk = $urandom;
		add_row(FMT_RI16, is_load ? LQA_OPCODE : STQA_OPCODE, rt, random_quad(), random_quad(),
			data, {junk[1:0], imm16}, wr);
	endtask

	task automatic add_other(input format_t f, input opcode_t o);
		add_row(f, o, 7'd99, random_quad(), random_quad(), random_quad(), random_imm(), 1'b1);
	endtask

	task automatic build_table();
		quad_t       d [0:7];
		logic [31:0] rnd;

		for (int k = 0; k < 8; k++) begin
			d[k] = random_quad();
		end

		// Untouched quadwords read back as zero
		add_x(1'b1, 7'd10, 32'd2, 32'd3, 1'b1, random_quad());
		add_d(1'b1, 7'd11, 32'd20, 10'd1, 1'b1, random_quad());
		add_a(1'b1, 7'd12, 16'd30, 1'b0, random_quad());

		// Store in one form, load back in another
		add_x(1'b0, 7'd13, 32'd30, 32'd10, 1'b1, d[0]);
		add_a(1'b1, 7'd14, 16'd40, 1'b1, random_quad());
		add_d(1'b0, 7'd15, 32'd50, 10'd5, 1'b1, d[1]);
		add_x(1'b1, 7'd16, 32'd50, 32'd5, 1'b1, random_quad());
		add_a(1'b0, 7'd17, 16'd70, 1'b1, d[2]);
		add_d(1'b1, 7'd18, 32'd60, 10'd10, 1'b1, random_quad());

		// Wraparound of the quadword index
		add_a(1'b0, 7'd19, 16'd2046, 1'b1, d[3]);
		add_d(1'b1, 7'd20, 32'd3, 10'h3fb, 1'b1, random_quad());	// 3 - 5 wraps to 2046
		add_d(1'b0, 7'd21, 32'd52, 10'd0, 1'b1, d[4]);
		add_x(1'b1, 7'd22, 32'd2000, 32'd100, 1'b1, random_quad());
		add_x(1'b1, 7'd23, 32'hffff_ffff, 32'd10, 1'b1, random_quad());
		add_a(1'b1, 7'd24, 16'hf846, 1'b1, random_quad());		// Low bits give 70

		// Nothing comes back from non-memory ops
		add_other(FMT_RR, 11'd0);
		add_other(FMT_RR, RR_OTHER);
		add_other(FMT_RI10, RI10_OTHER);
		add_other(FMT_RI16, RI16_OTHER);

		// Back-to-back ordering on one quadword
		add_x(1'b0, 7'd25, 32'd80, 32'd0, 1'b1, d[5]);
		add_a(1'b1, 7'd26, 16'd80, 1'b1, random_quad());
		add_a(1'b1, 7'd27, 16'd80, 1'b1, random_quad());	// Store right after still sees d[5]
		add_a(1'b0, 7'd28, 16'd80, 1'b1, d[6]);
		add_a(1'b1, 7'd29, 16'd80, 1'b1, random_quad());

		// Mixed traffic over quadwords 100 to 107
		for (int n = 0; n < NUM_RANDOM; n++) begin
			rnd = $urandom;
			case (rnd[2:1])
				2'd0: add_x(rnd[3], rnd[10:4], 32'd96, {29'd0, rnd[14:12]} + 32'd4, rnd[11],
					random_quad());
				2'd1: add_d(rnd[3], rnd[10:4], 32'd104, {7'd0, rnd[14:12]} - 10'd4, rnd[11],
					random_quad());
				2'd2: add_a(rnd[3], rnd[10:4], {13'd0, rnd[14:12]} + 16'd100, rnd[11],
					random_quad());
				default: begin
					case (rnd[4:3])
						2'd0: add_other(FMT_RR, 11'd0);
						2'd1: add_other(FMT_RR, RR_OTHER);
						2'd2: add_other(FMT_RI10, RI10_OTHER);
						default: add_other(FMT_RI16, RI16_OTHER);
					endcase
				end
			endcase
		end
	endtask

	// Expected writeback of one row, shadow memory updated after the read
	task automatic predict(input row_t r, output wb_t e);
		logic [31:0] wa;
		logic [31:0] sum;
		logic        ld_x;
		logic        st_x;
		logic        ld_d;
		logic        st_d;
		logic        ld_a;
		logic        st_a;
		ls_addr_t    addr;

		wa   = r.ra[0:31];
		ld_x = (r.format == FMT_RR) && (r.op == OP_LQX);
		st_x = (r.format == FMT_RR) && (r.op == OP_STQX);
		ld_d = (r.format == FMT_RI10) && (r.op[3:10] == OP_LQD);
		st_d = (r.format == FMT_RI10) && (r.op[3:10] == OP_STQD);
		ld_a = (r.format == FMT_RI16) && (r.op[2:10] == OP_LQA);
		st_a = (r.format == FMT_RI16) && (r.op[2:10] == OP_STQA);

		if (ld_x || st_x) begin
			sum = wa + r.rb[0:31];
		end else if (ld_d || st_d) begin
			sum = wa + {{22{r.imm[8]}}, r.imm[8:17]};
		end else begin
			sum = {16'h0000, r.imm[2:17]};
		end
		addr = sum[10:0];

		e = '0;
		if (ld_x || ld_d || ld_a) begin
			e.data      = shadow[addr];
			e.rt_addr   = r.rt_addr;
			e.reg_write = r.reg_write;
		end else if (st_x || st_d || st_a) begin
			e.rt_addr    = r.rt_addr;
			shadow[addr] = r.rt_st;
		end
	endtask

	task automatic drive_row(input row_t r);
		format    = r.format;
		op        = r.op;
		rt_addr   = r.rt_addr;
		ra        = r.ra;
		rb        = r.rb;
		rt_st     = r.rt_st;
		imm       = r.imm;
		reg_write = r.reg_write;
	endtask

	task automatic check_value(input string name, input logic [127:0] actual,
			input logic [127:0] exp_value);
		checks++;
		if (actual !== exp_value) begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_value, actual);
		end
	endtask

	initial begin
		row_t nop_row;
		wb_t  exp_wb;
		int   total;

		void'($urandom(50));
		nop_row = '0;
		reset   = 1'b1;
		drive_row(nop_row);
		shadow = '{default: '0};
		build_table();
		total         = rows.size() + WB_STAGES;
		timeout_limit = rows.size() + WB_STAGES + 20;

		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;

		for (int i = 0; i < total; i++) begin
			@(posedge clk);
			#1;
			if (i < WB_STAGES) begin
				exp_wb = '0;			// Only reset and nops in the pipe so far
			end else begin
				exp_wb = expected.pop_front();
			end
			check_value("rt_wb", rt_wb, exp_wb.data);
			check_value("rt_addr_wb", 128'(rt_addr_wb), 128'(exp_wb.rt_addr));
			check_value("reg_write_wb", 128'(reg_write_wb), 128'(exp_wb.reg_write));

			if (i < rows.size()) begin
				predict(rows[i], exp_wb);
				expected.push_back(exp_wb);
				drive_row(rows[i]);
			end else begin
				drive_row(nop_row);
			end
		end

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		wait (timeout_limit > 0);
		while (cycle_count < timeout_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run timed out after %0d cycles before the table finished", cycle_count);
		$display("Test failures found");
		$finish;
	end

endmodule

//--- spu_odd_ls.f
source/spu_types_pkg.sv
source/spu_isa_pkg.sv
source/odd_issue_if.sv
source/ls_req_if.sv
source/ls_addr_decode.sv
source/local_store.sv
source/spu_odd_ls.sv
dv/spu_odd_ls_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module spu_odd_ls_tb -f spu_odd_ls.f -o spu_odd_ls_sim

sim_output=$(./obj_dir/spu_odd_ls_sim)
echo "$sim_output"
echo "$sim_output" | grep -q 'All tests passed!'
